/* hdl/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// buffer geometry
// ROB_SIZE must be a power of two
`define ROB_SIZE 16
`define ROB_IDX_W 4

// lanes per cycle, dispatch and commit alike
`define DISP_W 2
`define WB_PORTS 2

// architectural and physical register widths
`define VREG_W 5
`define PREG_W 6

// an all-ones exception code means no exception
`define EXC_W 4
`define EXC_NONE {`EXC_W{1'b1}}

`endif

/* hdl/rob_entry_pkg.sv */
`include "rob_settings.svh"

package rob_entry_pkg;

    // position in the buffer
    // wrap flips each time the index passes the last entry
    typedef struct packed {
        logic wrap;
        logic [`ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    // payload kept per entry until it retires
    typedef struct packed {
        // destination register write enable
        logic we;
        logic [`VREG_W-1:0] vrd;
        logic [`PREG_W-1:0] prd;
        // mapping released at commit
        logic [`PREG_W-1:0] old_prd;
        logic store;
    } rob_entry_t;

endpackage

/* hdl/rob_bus_pkg.sv */
`include "rob_settings.svh"

package rob_bus_pkg;

    // one dispatch lane
    typedef struct packed {
        logic valid;
        rob_entry_pkg::rob_entry_t entry;
    } dispatch_t;

    // execution result status for one entry
    typedef struct packed {
        logic valid;
        rob_entry_pkg::rob_idx_t rob_idx;
        logic [`EXC_W-1:0] code;
    } writeback_t;

    // one retiring entry
    typedef struct packed {
        logic valid;
        rob_entry_pkg::rob_idx_t rob_idx;
        rob_entry_pkg::rob_entry_t entry;
    } commit_t;

    // the faulting entry, reported together with the flush
    typedef struct packed {
        logic valid;
        rob_entry_pkg::rob_idx_t rob_idx;
        logic [`EXC_W-1:0] code;
        rob_entry_pkg::rob_entry_t entry;
    } exc_report_t;

endpackage

/* hdl/rob_alloc.sv */
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_alloc (
    input  logic clk,
    input  logic rst,
    input  rob_bus_pkg::dispatch_t [`DISP_W-1:0] dispatch,
    input  logic [$clog2(`DISP_W + 1)-1:0] retire_num,
    input  logic flush,
    output logic full,
    output rob_entry_pkg::rob_idx_t [`DISP_W-1:0] alloc_idx,
    output logic [`DISP_W-1:0] alloc_en,
    output rob_entry_pkg::rob_idx_t head
);

    localparam int CNT_W = $clog2(`DISP_W + 1);
    localparam int OCC_W = `ROB_IDX_W + 1;

    rob_entry_pkg::rob_idx_t tail;
    logic [OCC_W-1:0] count;
    logic [OCC_W-1:0] free_num;
    logic [CNT_W-1:0] valid_num;
    logic [CNT_W-1:0] acc_num;

    // lanes are filled from lane 0 upward, so a count is enough
    always_comb begin
        valid_num = '0;
        for (int i = 0; i < `DISP_W; i++) begin
            valid_num = valid_num + CNT_W'(dispatch[i].valid);
        end
    end

    assign free_num = OCC_W'(`ROB_SIZE) - count;
    assign full = free_num < OCC_W'(valid_num);

    // all valid lanes go in together or none does
    // a flush cancels whatever dispatch offers in that cycle
    always_comb begin
        for (int i = 0; i < `DISP_W; i++) begin
            alloc_en[i] = dispatch[i].valid & ~full & ~flush;
            alloc_idx[i] = rob_entry_pkg::rob_idx_t'(tail + OCC_W'(i));
        end
    end

    always_comb begin
        acc_num = '0;
        for (int i = 0; i < `DISP_W; i++) begin
            acc_num = acc_num + CNT_W'(alloc_en[i]);
        end
    end

    // index and wrap bit advance as one counter
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (flush) begin
            // everything between head and tail is dropped
            head <= tail;
            count <= '0;
        end else begin
            head <= head + OCC_W'(retire_num);
            tail <= tail + OCC_W'(acc_num);
            count <= count + OCC_W'(acc_num) - OCC_W'(retire_num);
        end
    end

endmodule

/* hdl/rob_status.sv */
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_status (
    input  logic clk,
    input  logic rst,
    input  rob_bus_pkg::dispatch_t [`DISP_W-1:0] dispatch,
    input  logic [`DISP_W-1:0] alloc_en,
    input  rob_entry_pkg::rob_idx_t [`DISP_W-1:0] alloc_idx,
    input  rob_bus_pkg::writeback_t [`WB_PORTS-1:0] writeback,
    input  rob_entry_pkg::rob_idx_t head,
    input  logic flush,
    output rob_entry_pkg::rob_entry_t [`DISP_W-1:0] head_entry,
    output logic [`DISP_W-1:0] head_done,
    output logic [`DISP_W-1:0][`EXC_W-1:0] head_exc
);

    localparam int POS_W = `ROB_IDX_W + 1;

    rob_entry_pkg::rob_entry_t payload [`ROB_SIZE];
    logic [`EXC_W-1:0] exc_code [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] done;
    // wrap bit of the position each entry was allocated at
    logic [`ROB_SIZE-1:0] lap;
    rob_entry_pkg::rob_idx_t [`DISP_W-1:0] rd_pos;

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DISP_W; i++) begin
            if (alloc_en[i]) begin
                payload[alloc_idx[i].idx] <= dispatch[i].entry;
            end
        end
        for (int w = 0; w < `WB_PORTS; w++) begin
            if (writeback[w].valid) begin
                exc_code[writeback[w].rob_idx.idx] <= writeback[w].code;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done <= '0;
            lap <= '0;
        end else if (flush) begin
            done <= '0;
        end else begin
            for (int i = 0; i < `DISP_W; i++) begin
                if (alloc_en[i]) begin
                    done[alloc_idx[i].idx] <= 1'b0;
                    lap[alloc_idx[i].idx] <= alloc_idx[i].wrap;
                end
            end
            for (int w = 0; w < `WB_PORTS; w++) begin
                if (writeback[w].valid) begin
                    done[writeback[w].rob_idx.idx] <= 1'b1;
                end
            end
        end
    end

    // a retired entry keeps its done bit until it is allocated again,
    // so a done bit only counts when the entry belongs to the current lap
    always_comb begin
        for (int i = 0; i < `DISP_W; i++) begin
            rd_pos[i] = rob_entry_pkg::rob_idx_t'(head + POS_W'(i));
            head_entry[i] = payload[rd_pos[i].idx];
            head_exc[i] = exc_code[rd_pos[i].idx];
            head_done[i] = done[rd_pos[i].idx] & (lap[rd_pos[i].idx] == rd_pos[i].wrap);
        end
    end

endmodule

/* hdl/rob_retire.sv */
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_retire (
    input  logic clk,
    input  logic rst,
    input  rob_entry_pkg::rob_idx_t head,
    input  rob_entry_pkg::rob_entry_t [`DISP_W-1:0] head_entry,
    input  logic [`DISP_W-1:0] head_done,
    input  logic [`DISP_W-1:0][`EXC_W-1:0] head_exc,
    output rob_bus_pkg::commit_t [`DISP_W-1:0] commit,
    output rob_bus_pkg::exc_report_t exc,
    output logic [$clog2(`DISP_W + 1)-1:0] retire_num,
    output logic flush
);

    localparam int CNT_W = $clog2(`DISP_W + 1);
    localparam int POS_W = `ROB_IDX_W + 1;
    localparam int LANE_W = $clog2(`DISP_W);

    rob_entry_pkg::rob_idx_t [`DISP_W-1:0] lane_pos;
    logic [`DISP_W-1:0] exc_hit;
    logic [`DISP_W-1:0] run;
    logic [`DISP_W-1:0] commit_en;
    logic [`DISP_W-1:0] exc_en;
    logic [LANE_W-1:0] exc_lane;
    logic exc_any;

    logic [`DISP_W-1:0] commit_vld;
    rob_entry_pkg::rob_idx_t [`DISP_W-1:0] cm_pos;
    rob_entry_pkg::rob_entry_t [`DISP_W-1:0] cm_entry;
    rob_entry_pkg::rob_idx_t exc_pos;
    logic [`EXC_W-1:0] exc_code;
    rob_entry_pkg::rob_entry_t exc_entry;

    always_comb begin
        for (int i = 0; i < `DISP_W; i++) begin
            lane_pos[i] = rob_entry_pkg::rob_idx_t'(head + POS_W'(i));
            exc_hit[i] = head_exc[i] != `EXC_NONE;
        end
    end

    // in-order run of done entries from head, stopped by the first fault
    // nothing leaves while the previous fault is still flushing
    always_comb begin
        run[0] = head_done[0] & ~flush;
        for (int i = 1; i < `DISP_W; i++) begin
            run[i] = run[i-1] & ~exc_hit[i-1] & head_done[i];
        end
        commit_en = run & ~exc_hit;
        exc_en = run & exc_hit;
    end

    always_comb begin
        retire_num = '0;
        exc_lane = '0;
        for (int i = 0; i < `DISP_W; i++) begin
            retire_num = retire_num + CNT_W'(commit_en[i]);
            if (exc_en[i]) begin
                exc_lane = LANE_W'(i);
            end
        end
    end

    assign exc_any = |exc_en;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            commit_vld <= '0;
            flush <= 1'b0;
        end else begin
            commit_vld <= commit_en;
            flush <= exc_any;
        end
    end

    always_ff @(posedge clk) begin
        cm_pos <= lane_pos;
        cm_entry <= head_entry;
        exc_pos <= lane_pos[exc_lane];
        exc_code <= head_exc[exc_lane];
        exc_entry <= head_entry[exc_lane];
    end

    for (genvar i = 0; i < `DISP_W; i++) begin : g_commit
        assign commit[i] = '{valid: commit_vld[i], rob_idx: cm_pos[i], entry: cm_entry[i]};
    end

    // the report is valid exactly in the flush cycle
    assign exc = '{valid: flush, rob_idx: exc_pos, code: exc_code, entry: exc_entry};

endmodule

/* hdl/rob_top.sv */
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_top (
    input  logic clk,
    input  logic rst,
    input  rob_bus_pkg::dispatch_t [`DISP_W-1:0] dispatch,
    input  rob_bus_pkg::writeback_t [`WB_PORTS-1:0] writeback,
    output logic full,
    output rob_entry_pkg::rob_idx_t [`DISP_W-1:0] alloc_idx,
    output rob_bus_pkg::commit_t [`DISP_W-1:0] commit,
    output rob_bus_pkg::exc_report_t exc
);

    logic [`DISP_W-1:0] alloc_en;
    rob_entry_pkg::rob_idx_t head;
    logic [$clog2(`DISP_W + 1)-1:0] retire_num;
    logic flush;
    rob_entry_pkg::rob_entry_t [`DISP_W-1:0] head_entry;
    logic [`DISP_W-1:0] head_done;
    logic [`DISP_W-1:0][`EXC_W-1:0] head_exc;

    rob_alloc u_alloc (
        .clk(clk), .rst(rst), .dispatch(dispatch), .retire_num(retire_num),
        .flush(flush), .full(full), .alloc_idx(alloc_idx), .alloc_en(alloc_en),
        .head(head)
    );

    rob_status u_status (
        .clk(clk), .rst(rst), .dispatch(dispatch), .alloc_en(alloc_en),
        .alloc_idx(alloc_idx), .writeback(writeback), .head(head), .flush(flush),
        .head_entry(head_entry), .head_done(head_done), .head_exc(head_exc)
    );

    rob_retire u_retire (
        .clk(clk), .rst(rst), .head(head), .head_entry(head_entry),
        .head_done(head_done), .head_exc(head_exc), .commit(commit), .exc(exc),
        .retire_num(retire_num), .flush(flush)
    );

endmodule

/* test/rob_asserts.sv */
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_asserts (
    input logic clk,
    input logic rst,
    input logic full,
    input logic flush,
    input rob_entry_pkg::rob_idx_t head,
    input rob_entry_pkg::rob_idx_t tail,
    input rob_bus_pkg::commit_t [`DISP_W-1:0] commit,
    input rob_bus_pkg::exc_report_t exc
);

    // read by the testbench every cycle
    int fail_count = 0;

    // head equal to tail, wrap bit included, means empty
    a_full_when_empty: assert property (@(posedge clk) disable iff (!rst)
        head == tail |-> !full)
        else begin
            $error("full is high on an empty buffer");
            fail_count++;
        end

    a_lane_order: assert property (@(posedge clk) disable iff (!rst)
        commit[1].valid |-> commit[0].valid)
        else begin
            $error("commit lane 1 valid without lane 0");
            fail_count++;
        end

    // a reported fault empties the buffer at the same edge
    a_exc_with_flush: assert property (@(posedge clk) disable iff (!rst)
        exc.valid |=> head == tail)
        else begin
            $error("exception report without a flush of the buffer");
            fail_count++;
        end

    a_quiet_after_flush: assert property (@(posedge clk) disable iff (!rst)
        flush |=> !commit[0].valid && !commit[1].valid)
        else begin
            $error("commit in the cycle after a flush");
            fail_count++;
        end

endmodule

bind rob_top rob_asserts u_asserts (
    .clk(clk), .rst(rst), .full(full), .flush(flush), .head(head),
    .tail(alloc_idx[0]), .commit(commit), .exc(exc)
);

/* test/rob_tb.sv */
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_tb;

    localparam int POS_W = `ROB_IDX_W + 1;
    localparam int ENTRY_W = $bits(rob_entry_pkg::rob_entry_t);

    // one live entry of the reference model
    typedef struct packed {
        rob_entry_pkg::rob_idx_t idx;
        rob_entry_pkg::rob_entry_t entry;
        logic done;
        logic [`EXC_W-1:0] code;
    } slot_t;

    typedef struct packed {
        rob_bus_pkg::commit_t [`DISP_W-1:0] commit;
        rob_bus_pkg::exc_report_t exc;
    } outputs_t;

    logic clk;
    logic rst;
    rob_bus_pkg::dispatch_t [`DISP_W-1:0] dispatch;
    rob_bus_pkg::writeback_t [`WB_PORTS-1:0] writeback;
    logic full;
    rob_entry_pkg::rob_idx_t [`DISP_W-1:0] alloc_idx;
    rob_bus_pkg::commit_t [`DISP_W-1:0] commit;
    rob_bus_pkg::exc_report_t exc;

    slot_t model_q[$];
    logic [POS_W-1:0] model_tail;
    outputs_t expected;
    logic flush_now;
    logic accepted;
    int seed;
    int err_cnt;
    int n_commit;
    int n_exc;

    rob_top dut (
        .clk(clk), .rst(rst), .dispatch(dispatch), .writeback(writeback),
        .full(full), .alloc_idx(alloc_idx), .commit(commit), .exc(exc)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            err_cnt++;
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, got, want);
            stop_run();
        end
    endtask

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // registered outputs due after the next edge, from the oldest live entries
    function automatic outputs_t predict(input logic in_flush);
        outputs_t o;
        logic run;
        o = '0;
        run = !in_flush;
        for (int i = 0; i < `DISP_W; i++) begin
            run = run && i < model_q.size() && model_q[i].done;
            if (run && model_q[i].code != `EXC_NONE) begin
                o.exc = '{1'b1, model_q[i].idx, model_q[i].code, model_q[i].entry};
                run = 1'b0;
            end else if (run) begin
                o.commit[i] = '{1'b1, model_q[i].idx, model_q[i].entry};
            end
        end
        return o;
    endfunction

    task automatic advance_model();
        int n_valid;
        logic exp_full;
        outputs_t nxt;
        slot_t s;
        n_valid = 0;
        for (int i = 0; i < `DISP_W; i++) begin
            n_valid += int'(dispatch[i].valid);
        end
        exp_full = (`ROB_SIZE - model_q.size()) < n_valid;
        accepted = 1'b0;
        // the flush cycle cancels dispatch
        if (!flush_now) begin
            check_value("full", full, exp_full);
            accepted = !exp_full && n_valid > 0;
        end
        nxt = predict(flush_now);
        for (int i = 0; i < `DISP_W; i++) begin
            if (nxt.commit[i].valid) begin
                void'(model_q.pop_front());
            end
        end
        for (int w = 0; w < `WB_PORTS; w++) begin
            foreach (model_q[j]) begin
                if (writeback[w].valid && model_q[j].idx == writeback[w].rob_idx) begin
                    s = model_q[j];
                    s.done = 1'b1;
                    s.code = writeback[w].code;
                    model_q[j] = s;
                end
            end
        end
        if (accepted) begin
            for (int i = 0; i < n_valid; i++) begin
                s = '{model_tail + POS_W'(i), dispatch[i].entry, 1'b0, `EXC_NONE};
                check_value($sformatf("alloc_idx[%0d]", i), alloc_idx[i], s.idx);
                model_q.push_back(s);
            end
            model_tail = model_tail + POS_W'(n_valid);
        end
        // a fault drops every live entry including those just accepted
        if (nxt.exc.valid) begin
            model_q.delete();
        end
        expected = nxt;
        flush_now = nxt.exc.valid;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DISP_W; i++) begin
                check_value($sformatf("commit[%0d].valid", i), commit[i].valid,
                            expected.commit[i].valid);
                if (expected.commit[i].valid) begin
                    check_value($sformatf("commit[%0d]", i), commit[i], expected.commit[i]);
                end
                if (commit[i].valid) begin
                    n_commit++;
                end
            end
            check_value("exc.valid", exc.valid, expected.exc.valid);
            if (expected.exc.valid) begin
                check_value("exc", exc, expected.exc);
            end
            if (exc.valid) begin
                n_exc++;
            end
            check_value("assertion failures", dut.u_asserts.fail_count, 0);
            advance_model();
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic offer(input int n);
        for (int i = 0; i < `DISP_W; i++) begin
            dispatch[i].valid = i < n;
            dispatch[i].entry = rob_entry_pkg::rob_entry_t'(ENTRY_W'($random(seed)));
        end
    endtask

    // accepted tells about the previous cycle, so the offer drops right after its edge
    task automatic wait_accept();
        int waited;
        waited = 0;
        do begin
            next_cycle();
            waited++;
            if (waited > 60) begin
                $display("timeout: dispatch offer not accepted within 60 cycles");
                stop_run();
            end
        end while (!accepted);
        dispatch = '0;
    endtask

    task automatic dispatch_bundle(input int n);
        offer(n);
        wait_accept();
    endtask

    function automatic int pick_pending(input int skip);
        int cand[$];
        foreach (model_q[j]) begin
            if (!model_q[j].done && j != skip) cand.push_back(j);
        end
        if (cand.size() == 0) return -1;
        return cand[rand_below(cand.size())];
    endfunction

    // write back whatever is pending, oldest first, until nothing is live or due
    task automatic finish_all();
        int waited;
        int k;
        waited = 0;
        while (model_q.size() > 0 || flush_now || expected != '0) begin
            k = 0;
            writeback = '0;
            foreach (model_q[j]) begin
                if (!model_q[j].done && k < `WB_PORTS) begin
                    writeback[k] = '{1'b1, model_q[j].idx, `EXC_NONE};
                    k++;
                end
            end
            next_cycle();
            waited++;
            if (waited > 100) begin
                $display("timeout: buffer did not drain within 100 cycles");
                stop_run();
            end
        end
        writeback = '0;
    endtask

    initial begin
        int base;
        int exc_base;
        int a;
        int b;
        logic pending;
        logic [POS_W-1:0] pos_list [4];
        logic [POS_W-1:0] flushed_tail;
        clk = 1'b0;
        rst = 1'b0;
        dispatch = '0;
        writeback = '0;
        seed = 32'hccf7_f7a3;
        err_cnt = 0;
        n_commit = 0;
        n_exc = 0;
        model_tail = '0;
        expected = '0;
        flush_now = 1'b0;
        accepted = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        repeat (5) next_cycle();
        check_value("full after reset", full, 1'b0);

        // four entries written back youngest first
        base = n_commit;
        dispatch_bundle(2);
        dispatch_bundle(2);
        for (int j = 0; j < 4; j++) begin
            pos_list[j] = model_q[j].idx;
        end
        for (int j = 3; j >= 0; j--) begin
            writeback[0] = '{1'b1, pos_list[j], `EXC_NONE};
            next_cycle();
        end
        writeback = '0;
        finish_all();
        check_value("commits in order test", n_commit - base, 4);

        // fill all entries, then hold one more offer
        base = n_commit;
        for (int j = 0; j < 8; j++) begin
            dispatch_bundle(2);
        end
        offer(1);
        for (int j = 0; j < 3; j++) begin
            next_cycle();
            check_value("full on a full buffer", full, 1'b1);
        end
        writeback[0] = '{1'b1, model_q[0].idx, `EXC_NONE};
        writeback[1] = '{1'b1, model_q[1].idx, `EXC_NONE};
        next_cycle();
        writeback = '0;
        wait_accept();
        finish_all();
        check_value("commits in full buffer test", n_commit - base, 17);

        // fault on the second lane of a bundle with a younger entry behind it
        base = n_commit;
        exc_base = n_exc;
        dispatch_bundle(2);
        dispatch_bundle(1);
        flushed_tail = model_q[2].idx + POS_W'(1);
        writeback[0] = '{1'b1, model_q[2].idx, `EXC_NONE};
        writeback[1] = '{1'b1, model_q[1].idx, `EXC_W'(3)};
        next_cycle();
        writeback[0] = '{1'b1, model_q[0].idx, `EXC_NONE};
        writeback[1] = '0;
        next_cycle();
        writeback = '0;
        finish_all();
        check_value("commits in exception test", n_commit - base, 1);
        check_value("exceptions in exception test", n_exc - exc_base, 1);
        offer(1);
        check_value("index after flush", alloc_idx[0], flushed_tail);
        wait_accept();
        finish_all();

        // random traffic with occasional faults
        pending = 1'b0;
        for (int cyc = 0; cyc < 300; cyc++) begin
            if (pending && accepted) begin
                pending = 1'b0;
                dispatch = '0;
            end
            if (!pending && rand_below(3) != 0) begin
                offer(1 + rand_below(2));
                pending = 1'b1;
            end
            writeback = '0;
            a = rand_below(2) != 0 ? pick_pending(-1) : -1;
            b = rand_below(2) != 0 ? pick_pending(a) : -1;
            if (a >= 0) begin
                writeback[0] = '{1'b1, model_q[a].idx,
                                 rand_below(12) == 0 ? `EXC_W'(rand_below(15)) : `EXC_NONE};
            end
            if (b >= 0) begin
                writeback[1] = '{1'b1, model_q[b].idx,
                                 rand_below(12) == 0 ? `EXC_W'(rand_below(15)) : `EXC_NONE};
            end
            next_cycle();
        end
        writeback = '0;
        if (pending && !accepted) begin
            wait_accept();
        end
        dispatch = '0;
        finish_all();

        if (err_cnt == 0 && dut.u_asserts.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

/* files.f */
+incdir+hdl
hdl/rob_entry_pkg.sv
hdl/rob_bus_pkg.sv
hdl/rob_alloc.sv
hdl/rob_status.sv
hdl/rob_retire.sv
hdl/rob_top.sv
test/rob_asserts.sv
test/rob_tb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rob_entry_pkg.sv
      - hdl/rob_bus_pkg.sv
      - hdl/rob_alloc.sv
      - hdl/rob_status.sv
      - hdl/rob_retire.sv
      - hdl/rob_top.sv
      - target: test
        files:
          - test/rob_asserts.sv
          - test/rob_tb.sv
